// File: design/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// word and byte address widths of the shared memory bus
`define MEM_DATA_W 32
`define MEM_ADDR_W 16

// one byte enable per byte lane of a word
`define MEM_BE_W (`MEM_DATA_W / 8)

`define MEM_DEPTH 256

// software-visible configuration word
`define MEM_CFG_W 32

// data port first and 2 wait states
`define MEM_CFG_RESET 32'h0000_0004

`endif

// File: design/mem_bus_pkg.sv
`default_nettype none

`include "mem_cfg.svh"

package mem_bus_pkg;

	// request a cache port or the arbiter puts on a bus
	typedef struct packed {
		logic                   ren;
		logic                   wen;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata;
		logic [`MEM_BE_W-1:0]   byte_en;
	} bus_req_t;

	// busy is low for exactly one cycle when a request completes
	typedef struct packed {
		logic                   busy;
		logic [`MEM_DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef enum logic {
		DATA_FIRST  = 1'b0,
		INSTR_FIRST = 1'b1
	} arb_prio_e;

	// field layout of the configuration word with prio in bit 0
	typedef struct packed {
		logic [`MEM_CFG_W-6:0] reserved;
		logic [3:0]            wait_states;
		arb_prio_e             prio;
	} cfg_fields_t;

	// written as a raw word, read back by the hardware as fields
	typedef union packed {
		logic [`MEM_CFG_W-1:0] raw;
		cfg_fields_t           fields;
	} cfg_word_u;

endpackage

`default_nettype wire

// File: design/arb_config_regs.sv
`default_nettype none

`include "mem_cfg.svh"

module arb_config_regs (
	input  wire logic                    CLK,
	input  wire logic                    nRST,
	input  wire logic                    cfg_we,
	input  wire logic [`MEM_CFG_W-1:0]   cfg_wdata,
	output mem_bus_pkg::cfg_fields_t     cfg
);

	mem_bus_pkg::cfg_word_u cfg_q;

	always_ff @(posedge CLK, negedge nRST) begin : cfg_reg
		if (!nRST) begin
			cfg_q.raw <= `MEM_CFG_RESET;
		end else if (cfg_we) begin
			cfg_q.raw <= cfg_wdata; // takes effect on the next cycle
		end
	end

	// the arbiter and the RAM only look at the decoded fields
	always_comb begin : cfg_decode
		cfg = cfg_q.fields;
		cfg.reserved = '0; // reserved bits read as zero whatever was written
	end

endmodule

`default_nettype wire

// File: design/memory_arbiter.sv
`default_nettype none

module memory_arbiter (
	input  wire logic                CLK,
	input  wire logic                nRST,
	input  mem_bus_pkg::bus_req_t    icache_req,
	input  mem_bus_pkg::bus_req_t    dcache_req,
	output mem_bus_pkg::bus_rsp_t    icache_rsp,
	output mem_bus_pkg::bus_rsp_t    dcache_rsp,
	output mem_bus_pkg::bus_req_t    mem_req,
	input  mem_bus_pkg::bus_rsp_t    mem_rsp,
	input  mem_bus_pkg::arb_prio_e   prio
);

	typedef enum logic [1:0] {
		IDLE,
		IREQUEST,
		DREQUEST,
		RETIRE
	} state_t;

	// what a port sees while it is not the owner
	localparam mem_bus_pkg::bus_rsp_t RSP_IDLE = '{busy: 1'b1, rdata: '0};

	state_t state;
	state_t next_state;

	mem_bus_pkg::bus_req_t next_mem_req;
	mem_bus_pkg::bus_rsp_t next_icache_rsp;
	mem_bus_pkg::bus_rsp_t next_dcache_rsp;

	logic i_valid;
	logic d_valid;
	logic i_win;
	logic d_win;

	assign i_valid = icache_req.ren || icache_req.wen;
	assign d_valid = dcache_req.ren || dcache_req.wen;

	// prio only decides a tie and a lone requester always wins
	assign d_win = d_valid && (prio == mem_bus_pkg::DATA_FIRST || !i_valid);
	assign i_win = i_valid && !d_win;

	always_ff @(posedge CLK, negedge nRST) begin : output_regs
		if (!nRST) begin
			icache_rsp <= RSP_IDLE;
			dcache_rsp <= RSP_IDLE;
			mem_req    <= '0;
		end else begin
			icache_rsp <= next_icache_rsp;
			dcache_rsp <= next_dcache_rsp;
			mem_req    <= next_mem_req;
		end
	end

	always_comb begin : next_output_logic
		next_mem_req    = '0;
		next_icache_rsp = RSP_IDLE;
		next_dcache_rsp = RSP_IDLE;

		case (state)
			IDLE: begin
				if (mem_rsp.busy && d_win) begin
					next_mem_req    = dcache_req;
					next_dcache_rsp = mem_rsp;
				end else if (mem_rsp.busy && i_win) begin
					next_mem_req    = icache_req;
					next_icache_rsp = mem_rsp;
				end
			end
			IREQUEST: begin
				next_icache_rsp = mem_rsp; // owner sees the RAM one cycle late
				if (mem_rsp.busy) begin
					next_mem_req = icache_req;
				end
			end
			DREQUEST: begin
				next_dcache_rsp = mem_rsp;
				if (mem_rsp.busy) begin
					next_mem_req = dcache_req;
				end
			end
			default: begin
				next_mem_req = '0; // the old owner may still hold its request here
			end
		endcase
	end

	always_comb begin : next_state_logic
		next_state = state;

		case (state)
			IDLE: begin
				if (mem_rsp.busy && d_win) begin
					next_state = DREQUEST;
				end else if (mem_rsp.busy && i_win) begin
					next_state = IREQUEST;
				end
			end
			IREQUEST: begin
				if (!mem_rsp.busy) begin
					next_state = RETIRE;
				end
			end
			DREQUEST: begin
				if (!mem_rsp.busy) begin
					next_state = RETIRE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin : state_reg
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

// File: design/wait_state_ram.sv
`default_nettype none

`include "mem_cfg.svh"

module wait_state_ram (
	input  wire logic              CLK,
	input  wire logic              nRST,
	input  mem_bus_pkg::bus_req_t  req,
	output mem_bus_pkg::bus_rsp_t  rsp,
	input  wire logic [3:0]        wait_states
);

	localparam int IDX_W = $clog2(`MEM_DEPTH);

	typedef enum logic {
		RAM_IDLE,
		RAM_WAIT
	} ram_state_t;

	logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];

	ram_state_t       state;
	logic [3:0]       count;
	logic [IDX_W-1:0] idx;
	logic             start;
	logic             finish;

	assign idx = req.addr[IDX_W+1:2]; // word index from the byte address

	// busy low means the last request completes this cycle and is still on the bus
	assign start  = (state == RAM_IDLE) && rsp.busy && (req.ren || req.wen);
	assign finish = (start && wait_states == 4'd0) || (state == RAM_WAIT && count == 4'd0);

	always_ff @(posedge CLK, negedge nRST) begin : ctrl_regs
		if (!nRST) begin
			state     <= RAM_IDLE;
			count     <= '0;
			rsp.busy  <= 1'b1;
			rsp.rdata <= '0;
		end else begin
			rsp.busy  <= !finish;
			rsp.rdata <= (finish && req.ren) ? mem[idx] : '0;

			if (finish) begin
				state <= RAM_IDLE;
			end else if (start) begin
				state <= RAM_WAIT;
				count <= wait_states - 4'd1;
			end else if (state == RAM_WAIT) begin
				count <= count - 4'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin : mem_write
		if (finish && req.wen) begin
			for (int b = 0; b < `MEM_BE_W; b++) begin
				if (req.byte_en[b]) begin
					mem[idx][8*b +: 8] <= req.wdata[8*b +: 8]; // untouched lanes keep old bytes
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/mem_subsystem.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_subsystem (
	input  wire logic                  CLK,
	input  wire logic                  nRST,
	input  mem_bus_pkg::bus_req_t      icache_req,
	input  mem_bus_pkg::bus_req_t      dcache_req,
	output mem_bus_pkg::bus_rsp_t      icache_rsp,
	output mem_bus_pkg::bus_rsp_t      dcache_rsp,
	input  wire logic                  cfg_we,
	input  wire logic [`MEM_CFG_W-1:0] cfg_wdata
);

	mem_bus_pkg::cfg_fields_t cfg;
	mem_bus_pkg::bus_req_t    mem_req;
	mem_bus_pkg::bus_rsp_t    mem_rsp;

	arb_config_regs u_cfg (
		.CLK       (CLK),
		.nRST      (nRST),
		.cfg_we    (cfg_we),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	memory_arbiter u_arb (
		.CLK        (CLK),
		.nRST       (nRST),
		.icache_req (icache_req),
		.dcache_req (dcache_req),
		.icache_rsp (icache_rsp),
		.dcache_rsp (dcache_rsp),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.prio       (cfg.prio)
	);

	// main memory stand-in
	wait_state_ram u_ram (
		.CLK         (CLK),
		.nRST        (nRST),
		.req         (mem_req),
		.rsp         (mem_rsp),
		.wait_states (cfg.wait_states)
	);

endmodule

`default_nettype wire

// File: bench/mem_subsystem_asserts.sv
`default_nettype none

module mem_subsystem_asserts (
	input  wire logic                CLK,
	input  wire logic                nRST,
	input  wire logic [1:0]          state,
	input  mem_bus_pkg::bus_req_t    mem_req,
	input  mem_bus_pkg::bus_rsp_t    mem_rsp
);

	localparam logic [1:0] ST_RETIRE = 2'd3; // encoding of RETIRE in the arbiter FSM

	logic mem_valid;

	assign mem_valid = mem_req.ren || mem_req.wen;

	no_issue_in_retire: assert property (@(posedge CLK) disable iff (!nRST)
		state == ST_RETIRE |-> !mem_valid)
		else $error("memory request issued while the arbiter was in RETIRE");

	mem_ren_wen_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
		else $error("memory request raised ren and wen together");

	// the RAM relies on a steady request until it answers
	mem_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		mem_valid && mem_rsp.busy |=> $stable(mem_req))
		else $error("memory request changed while the RAM was busy");

endmodule

bind memory_arbiter mem_subsystem_asserts u_asserts (
	.CLK     (CLK),
	.nRST    (nRST),
	.state   (state),
	.mem_req (mem_req),
	.mem_rsp (mem_rsp)
);

`default_nettype wire

// File: bench/mem_subsystem_tb.sv
`default_nettype none

`include "mem_cfg.svh"

module mem_subsystem_tb;

	localparam int RESET_CYCLES    = 10;
	localparam int FIELDS          = 7; // columns per line of the data file
	localparam int MAX_LINES       = 64;
	localparam int CYCLES_PER_LINE = 40;

	logic                  CLK;
	logic                  nRST;
	mem_bus_pkg::bus_req_t icache_req;
	mem_bus_pkg::bus_req_t dcache_req;
	mem_bus_pkg::bus_rsp_t icache_rsp;
	mem_bus_pkg::bus_rsp_t dcache_rsp;
	logic                  cfg_we;
	logic [`MEM_CFG_W-1:0] cfg_wdata;

	logic [31:0] td [FIELDS*MAX_LINES];

	integer                seed;
	int                    cycles;
	int                    limit;
	int                    n_lines;
	int                    checks;
	int                    value_errs;
	int                    timing_errs;
	int                    other_errs;
	logic [`MEM_CFG_W-1:0] cur_cfg;

	mem_subsystem dut (
		.CLK        (CLK),
		.nRST       (nRST),
		.icache_req (icache_req),
		.dcache_req (dcache_req),
		.icache_rsp (icache_rsp),
		.dcache_rsp (dcache_rsp),
		.cfg_we     (cfg_we),
		.cfg_wdata  (cfg_wdata)
	);

	always #50 CLK = ~CLK;

	function automatic int cfg_wait_states(input logic [`MEM_CFG_W-1:0] cfg);
		return int'(cfg[4:1]); // wait states sit just above the priority bit
	endfunction

	function automatic logic cfg_data_first(input logic [`MEM_CFG_W-1:0] cfg);
		return cfg[0] == 1'b0;
	endfunction

	task automatic report_counts();
		$display("Checks: %0d, value errors: %0d, timing errors: %0d, other errors: %0d",
			checks, value_errs, timing_errs, other_errs);
	endtask

	// cycle count for completion times and the watchdog
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			report_counts();
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			$display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_idle_outputs();
		check_value("icache_rsp.busy", 32'd1, {31'd0, icache_rsp.busy});
		check_value("dcache_rsp.busy", 32'd1, {31'd0, dcache_rsp.busy});
		check_value("icache_rsp.rdata", 32'd0, icache_rsp.rdata);
		check_value("dcache_rsp.rdata", 32'd0, dcache_rsp.rdata);
	endtask

	task automatic drive_req(input logic port, input mem_bus_pkg::bus_req_t req);
		if (port) begin
			dcache_req <= req;
		end else begin
			icache_req <= req;
		end
	endtask

	task automatic write_config(input logic [`MEM_CFG_W-1:0] value);
		@(posedge CLK);
		cfg_we    <= 1'b1;
		cfg_wdata <= value;
		@(posedge CLK);
		cfg_we  <= 1'b0;
		cur_cfg = value;
	endtask

	task automatic idle_gap();
		int gap;
		gap = {$random(seed)} % 4;
		repeat (gap) @(posedge CLK);
	endtask

	// one cache model access following the request rule
	task automatic run_transaction(input int line, input logic chk_lat, output int done);
		mem_bus_pkg::bus_req_t req;
		mem_bus_pkg::bus_rsp_t rsp;
		logic                  port;
		logic [31:0]           exp;
		string                 name;
		int                    edges;
		int                    ws;
		port        = td[FIELDS*line+1][0];
		req.wen     = td[FIELDS*line][0];
		req.ren     = td[FIELDS*line][1];
		req.addr    = td[FIELDS*line+2][`MEM_ADDR_W-1:0];
		req.wdata   = td[FIELDS*line+3];
		req.byte_en = td[FIELDS*line+4][`MEM_BE_W-1:0];
		exp         = req.wen ? 32'd0 : td[FIELDS*line+6]; // a write answers with zero data
		name        = port ? "dcache_rsp" : "icache_rsp";
		ws          = cfg_wait_states(cur_cfg);
		edges       = 0;
		@(posedge CLK);
		drive_req(port, req);
		do begin
			@(posedge CLK);
			edges++;
			@(negedge CLK);
			rsp = port ? dcache_rsp : icache_rsp;
		end while (rsp.busy);
		done = cycles;
		if (chk_lat) begin
			checks++;
			assert (edges - 1 == ws + 2) else begin
				$display("Fail at %0t: %s.busy latency expected %0d edges, actual %0d",
					$time, name, ws + 2, edges - 1);
				timing_errs++;
			end
		end
		check_value({name, ".rdata"}, exp, rsp.rdata);
		@(posedge CLK);
		drive_req(port, '0); // dropped on the edge that samples busy low
		@(negedge CLK);
		rsp = port ? dcache_rsp : icache_rsp;
		check_value({name, ".busy"}, 32'd1, {31'd0, rsp.busy}); // pulse lasts one cycle
	endtask

	task automatic compare_order(input int line, input int done_a, input int done_b);
		logic port_a;
		logic port_b;
		int   d_done;
		int   i_done;
		port_a = td[FIELDS*line+1][0];
		port_b = td[FIELDS*(line+1)+1][0];
		d_done = port_a ? done_a : done_b;
		i_done = port_a ? done_b : done_a;
		checks++;
		assert (port_a != port_b) else begin
			$display("Paired lines %0d and %0d name the same cache port", line, line + 1);
			other_errs++;
		end
		if (cfg_data_first(cur_cfg)) begin
			assert (d_done < i_done) else begin
				$display("At %0t the data port did not complete first under data priority",
					$time);
				timing_errs++;
			end
		end else begin
			assert (i_done < d_done) else begin
				$display("At %0t the instruction port was not first under instruction priority",
					$time);
				timing_errs++;
			end
		end
	endtask

	initial begin : main
		int          i;
		int          done_a;
		int          done_b;
		logic [31:0] op;
		CLK         = 1'b0;
		nRST        = 1'b0;
		icache_req  = '0;
		dcache_req  = '0;
		cfg_we      = 1'b0;
		cfg_wdata   = '0;
		seed        = 19;
		cycles      = 0;
		checks      = 0;
		value_errs  = 0;
		timing_errs = 0;
		other_errs  = 0;
		cur_cfg     = `MEM_CFG_RESET;
		$readmemh("bench/mem_subsystem_testdata.hex", td);
		n_lines = 0;
		while (n_lines < MAX_LINES && !$isunknown(td[FIELDS*n_lines])
			&& td[FIELDS*n_lines] != 32'd0) begin
			n_lines++;
		end
		limit = CYCLES_PER_LINE * n_lines + RESET_CYCLES;
		assert (n_lines > 0) else begin
			$display("No transactions were read from the data file");
			other_errs++;
		end

		repeat (RESET_CYCLES - 1) begin
			@(negedge CLK);
			check_idle_outputs();
		end
		@(posedge CLK);
		nRST <= 1'b1;
		repeat (2) begin
			@(negedge CLK);
			check_idle_outputs();
		end

		i = 0;
		while (i < n_lines) begin
			op = td[FIELDS*i];
			if (td[FIELDS*i+5] != cur_cfg) begin
				write_config(td[FIELDS*i+5]);
			end
			idle_gap();
			if (op[2] && i + 1 < n_lines) begin
				fork
					run_transaction(i, 1'b0, done_a);
					run_transaction(i + 1, 1'b0, done_b);
				join
				compare_order(i, done_a, done_b);
				i += 2;
			end else begin
				run_transaction(i, 1'b1, done_a); // arbiter is idle here
				i += 1;
			end
		end

		report_counts();
		if (value_errs + timing_errs + other_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/mem_subsystem_testdata.hex
// op port addr wdata byte_en cfg expected_rdata, all in hex
// op 1 write, 2 read, plus 4 pairs the line with the next, 0 ends; port 0 icache, 1 dcache
1 1 0010 11223344 F 00000004 00000000
1 1 0010 AABBCCDD 5 00000004 00000000
2 1 0010 00000000 F 00000004 11BB33DD
1 1 0014 DEADBEEF F 00000004 00000000
1 1 0014 00000077 1 00000004 00000000
2 0 0014 00000000 F 00000004 DEADBE77
1 1 0018 CAFEF00D F 00000004 00000000
1 1 0018 12345678 A 00000004 00000000
2 1 0018 00000000 F 00000004 12FE560D
1 1 0100 01020304 F 00000000 00000000
2 1 0100 00000000 F 00000000 01020304
2 0 0100 00000000 F 00000000 01020304
1 1 0104 A0B0C0D0 F 00000002 00000000
2 0 0104 00000000 F 00000002 A0B0C0D0
1 1 0108 0F1E2D3C F 00000006 00000000
2 1 0108 00000000 F 00000006 0F1E2D3C
1 1 010C 5A5A5A5A F 0000000A 00000000
2 0 010C 00000000 F 0000000A 5A5A5A5A
1 1 0110 89ABCDEF F 0000001E 00000000
2 1 0110 00000000 F 0000001E 89ABCDEF
2 0 0100 00000000 F A5A5A502 01020304
6 0 0010 00000000 F 00000004 11BB33DD
2 1 0014 00000000 F 00000004 DEADBE77
6 1 0018 00000000 F 00000005 12FE560D
2 0 0100 00000000 F 00000005 01020304
5 1 0200 55AA55AA F 00000001 00000000
2 0 0104 00000000 F 00000001 A0B0C0D0
2 1 0200 00000000 F 00000001 55AA55AA
1 1 0300 00000001 F 00000000 00000000
2 1 0300 00000000 F 00000000 00000001
1 1 0300 00000102 2 00000000 00000000
2 1 0300 00000000 F 00000000 00000101
1 1 0304 FFFFFFFF F 00000000 00000000
1 1 0304 00000000 3 00000000 00000000
2 1 0304 00000000 F 00000000 FFFF0000
1 1 0308 11111111 F 00000000 00000000
1 1 030C 22222222 F 00000000 00000000
2 1 0308 00000000 F 00000000 11111111
2 0 030C 00000000 F 00000000 22222222
6 1 0300 00000000 F 00000006 00000101
2 0 0304 00000000 F 00000006 FFFF0000
0 0 0000 00000000 0 00000000 00000000

// File: project.f
+incdir+design
design/mem_bus_pkg.sv
design/arb_config_regs.sv
design/memory_arbiter.sv
design/wait_state_ram.sv
design/mem_subsystem.sv
bench/mem_subsystem_asserts.sv
bench/mem_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
		! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
